// File: la_top.f
common/la_pkg.sv
design/la_sampler.sv
la_trigger/la_trigger.sv
la_capture/la_capture_buffer.sv
design/la_readout.sv
design/la_top.sv
sim/la_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the logic analyzer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module la_tb -f la_top.f -o la_sim

./obj_dir/la_sim | tee sim.log

# The testbench prints its fail line on any failed check
if grep -q "tests failed" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation passed"

// File: sim/la_tb.sv
// ******************************
// Logic analyzer capture testbench
// Counter on the probe lines, trigger stimulus
// per test, checks on the readout stream
// ******************************

`timescale 1ns/1ns

module la_tb;

  logic                               clk;
  logic                               reset;
  // Free-running counter, so every sample value is predictable
  logic [la_pkg::DATA_WIDTH-1:0]      probe = '0;
  logic [la_pkg::TRIG_WIDTH-1:0]      ext_trigger;
  logic [la_pkg::DIV_WIDTH-1:0]       sample_div;
  logic [la_pkg::PROBE_WIDTH-1:0]     edge_detect_enable;
  logic [la_pkg::PROBE_WIDTH-1:0]     rise_edge_enable;
  logic [la_pkg::PROBE_WIDTH-1:0]     fall_edge_enable;
  logic [la_pkg::PROBE_WIDTH-1:0]     low_level_enable;
  logic [la_pkg::PROBE_WIDTH-1:0]     high_level_enable;
  logic                               trigger_logic;
  logic                               arm;
  logic                               capture_done;
  logic                               out_valid;
  logic [la_pkg::PROBE_WIDTH-1:0]     out_sample;
  logic                               trigger_out;

  // Last record seen on the readout
  logic [la_pkg::PROBE_WIDTH-1:0]     record [la_pkg::BUF_DEPTH];
  logic                               record_ok;
  logic [15:0]                        lfsr_state;
  int                                 test_errors;
  int                                 tests_run;
  int                                 tests_failed;

  la_top uut (
    .clk(clk), .reset(reset), .probe(probe), .ext_trigger(ext_trigger),
    .sample_div(sample_div), .edge_detect_enable(edge_detect_enable),
    .rise_edge_enable(rise_edge_enable), .fall_edge_enable(fall_edge_enable),
    .low_level_enable(low_level_enable), .high_level_enable(high_level_enable),
    .trigger_logic(trigger_logic), .arm(arm), .capture_done(capture_done),
    .out_valid(out_valid), .out_sample(out_sample), .trigger_out(trigger_out));

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    probe <= probe + 1'b1;
  end

  // ******************************
  // Helpers

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[0] ^ state[2] ^ state[3] ^ state[5];
    return {feedback, state[15:1]};
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_true(input string name, input logic cond, input string what);
    assert (cond) else begin
      $display("%s: %s", name, what);
      test_errors++;
    end
  endtask

  // Divider and masks, then a few periods for the divider to settle
  task automatic configure(input logic [7:0] div, input logic use_and,
                           input logic [17:0] edge_mask, input logic [17:0] rise_mask,
                           input logic [17:0] fall_mask, input logic [17:0] low_mask,
                           input logic [17:0] high_mask, input logic [1:0] lines);
    @(posedge clk);
    sample_div <= div;
    trigger_logic <= use_and;
    edge_detect_enable <= edge_mask;
    rise_edge_enable <= rise_mask;
    fall_edge_enable <= fall_mask;
    low_level_enable <= low_mask;
    high_level_enable <= high_mask;
    ext_trigger <= lines;
    repeat (16) @(posedge clk);
  endtask

  task automatic arm_capture();
    @(posedge clk);
    arm <= 1'b1;
    @(posedge clk);
    arm <= 1'b0;
  endtask

  task automatic wait_samples(input int count);
    repeat (count * (int'(sample_div) + 1)) @(posedge clk);
  endtask

  task automatic set_trigger_lines(input logic [1:0] lines);
    @(posedge clk);
    ext_trigger <= lines;
  endtask

  // Waits for done and the readout, collects it and checks continuity
  task automatic capture_record(input string name);
    int waited;
    int count;
    logic [15:0] step;
    logic [15:0] expected;
    logic trigger_seen;
    step = 16'(sample_div) + 16'd1;
    record_ok = 1'b0;
    trigger_seen = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!capture_done && waited < 1000) begin
      trigger_seen |= trigger_out;
      @(negedge clk);
      waited++;
    end
    check_true(name, capture_done, "capture done did not rise within 1000 clocks");
    if (!capture_done) return;
    // Trigger level must have fired before the post-fill could finish
    check_true(name, trigger_seen, "trigger output never went high before capture done");
    waited = 0;
    while (!out_valid && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    check_true(name, out_valid, "readout strobe did not start after capture done");
    if (!out_valid) return;
    count = 0;
    while (out_valid && count < la_pkg::BUF_DEPTH) begin
      record[count] = out_sample;
      count++;
      @(negedge clk);
    end
    check_value(name, "strobe count", la_pkg::BUF_DEPTH, count);
    check_true(name, !out_valid, "readout strobe ran past the end of the record");
    // Counter advances by the sample period between words
    for (int i = 1; i < count; i++) begin
      expected = record[i-1][15:0] + step;
      check_value(name, $sformatf("word %0d data", i), 32'(expected), 32'(record[i][15:0]));
    end
    record_ok = (count == la_pkg::BUF_DEPTH);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // ******************************
  // Test sequence
  initial begin
    logic [la_pkg::PROBE_WIDTH-1:0] rand_mask;
    logic                           lone_seen;
    int                             idle_count;
    reset = 1'b1;
    ext_trigger = '0;
    sample_div = '0;
    edge_detect_enable = '0;
    rise_edge_enable = '0;
    fall_edge_enable = '0;
    low_level_enable = '0;
    high_level_enable = '0;
    trigger_logic = 1'b0;
    arm = 1'b0;
    record_ok = 1'b0;
    lfsr_state = 16'd10;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Continuity at divider 3, any edge on bit 16
    configure(8'd3, 1'b0, 18'h10000, '0, '0, '0, '0, 2'b00);
    arm_capture();
    wait_samples(la_pkg::PRE_SAMPLES + 4);
    set_trigger_lines(2'b01);
    capture_record("record_continuity");
    finish_test("record_continuity");

    // OR mode, rise on bit 16
    configure(8'd1, 1'b0, '0, 18'h10000, '0, '0, '0, 2'b00);
    arm_capture();
    wait_samples(la_pkg::PRE_SAMPLES + 4);
    set_trigger_lines(2'b01);
    capture_record("or_rise_bit16");
    if (record_ok) begin
      for (int i = 0; i < la_pkg::PRE_SAMPLES; i++) begin
        check_value("or_rise_bit16", $sformatf("word %0d bit 16", i), 0, 32'(record[i][16]));
      end
      check_value("or_rise_bit16", "trigger word bit 16", 1,
                  32'(record[la_pkg::PRE_SAMPLES][16]));
    end
    finish_test("or_rise_bit16");

    // Fall on bit 17, line held high through the pre-fill
    configure(8'd0, 1'b0, '0, '0, 18'h20000, '0, '0, 2'b10);
    arm_capture();
    wait_samples(la_pkg::PRE_SAMPLES + 4);
    set_trigger_lines(2'b00);
    capture_record("fall_bit17");
    if (record_ok) begin
      for (int i = 0; i < la_pkg::PRE_SAMPLES; i++) begin
        check_value("fall_bit17", $sformatf("word %0d bit 17", i), 1, 32'(record[i][17]));
      end
      check_value("fall_bit17", "trigger word bit 17", 0, 32'(record[la_pkg::PRE_SAMPLES][17]));
    end
    finish_test("fall_bit17");

    // AND mode, a lone rise on 17 first, then 16 high and 17 rising again
    configure(8'd2, 1'b1, '0, 18'h20000, '0, '0, 18'h10000, 2'b00);
    arm_capture();
    wait_samples(la_pkg::PRE_SAMPLES + 4);
    set_trigger_lines(2'b10);
    wait_samples(4);
    set_trigger_lines(2'b00);
    wait_samples(4);
    set_trigger_lines(2'b01);
    wait_samples(4);
    set_trigger_lines(2'b11);
    capture_record("and_high16_rise17");
    if (record_ok) begin
      check_value("and_high16_rise17", "trigger word bit 16", 1,
                  32'(record[la_pkg::PRE_SAMPLES][16]));
      check_value("and_high16_rise17", "trigger word bit 17", 1,
                  32'(record[la_pkg::PRE_SAMPLES][17]));
      check_value("and_high16_rise17", "word before trigger bit 17", 0,
                  32'(record[la_pkg::PRE_SAMPLES-1][17]));
      lone_seen = 1'b0;
      for (int i = 0; i < la_pkg::PRE_SAMPLES; i++) begin
        if (record[i][17] && !record[i][16]) lone_seen = 1'b1;
      end
      check_true("and_high16_rise17", lone_seen, "lone rise on bit 17 missing before trigger");
    end
    finish_test("and_high16_rise17");

    // Re-arm after the readout above, random rise mask on counter bits 3..0
    rand_mask = '0;
    for (int b = 0; b < 4; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      rand_mask[b] = lfsr_state[0];
    end
    if (rand_mask == '0) rand_mask[0] = 1'b1;
    configure(8'd0, 1'b0, '0, rand_mask, '0, '0, '0, 2'b00);
    arm_capture();
    capture_record("rearm_lfsr_rise");
    if (record_ok) begin
      check_true("rearm_lfsr_rise",
                 |(~record[la_pkg::PRE_SAMPLES-1] & record[la_pkg::PRE_SAMPLES] & rand_mask),
                 "trigger word shows no rise on an enabled bit");
    end
    finish_test("rearm_lfsr_rise");

    // Empty masks, running out the 400 clocks is the good outcome
    configure(8'd0, 1'b0, '0, '0, '0, '0, '0, 2'b00);
    arm_capture();
    idle_count = 0;
    while (!capture_done && !out_valid && idle_count < 400) begin
      @(negedge clk);
      idle_count++;
    end
    check_true("no_trigger", !capture_done && !out_valid,
               "capture completed with every trigger mask empty");
    finish_test("no_trigger");

    $display("Tests run %0d, passed %0d, failed %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: design/la_top.sv
// ******************************
// Logic analyzer capture top
// Sampler, trigger, capture buffer, readout
// ******************************

`timescale 1ns/1ns

module la_top (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [la_pkg::DATA_WIDTH-1:0]      probe,
  input  logic [la_pkg::TRIG_WIDTH-1:0]      ext_trigger,
  input  logic [la_pkg::DIV_WIDTH-1:0]       sample_div,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     edge_detect_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     rise_edge_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     fall_edge_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     low_level_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     high_level_enable,
  input  logic                               trigger_logic,
  input  logic                               arm,
  output logic                               capture_done,
  output logic                               out_valid,
  output logic [la_pkg::PROBE_WIDTH-1:0]     out_sample,
  output logic                               trigger_out
);

  // Decimated sample stream
  logic [la_pkg::PROBE_WIDTH-1:0] sample;
  logic                           sample_valid;
  // Buffer read side
  logic [la_pkg::ADDR_WIDTH-1:0]  rd_addr;
  logic [la_pkg::PROBE_WIDTH-1:0] rd_data;
  logic [la_pkg::ADDR_WIDTH-1:0]  start_addr;
  logic                           read_finished;

  la_sampler i_sampler (
    .clk(clk), .reset(reset), .probe(probe), .ext_trigger(ext_trigger),
    .sample_div(sample_div), .sample(sample), .sample_valid(sample_valid));

  la_trigger i_trigger (
    .clk(clk), .reset(reset), .sample(sample), .sample_valid(sample_valid),
    .edge_detect_enable(edge_detect_enable), .rise_edge_enable(rise_edge_enable),
    .fall_edge_enable(fall_edge_enable), .low_level_enable(low_level_enable),
    .high_level_enable(high_level_enable), .trigger_logic(trigger_logic),
    .trigger_out(trigger_out));

  // Buffer sees the trigger level two clocks after each sample
  la_capture_buffer i_capture_buffer (
    .clk(clk), .reset(reset), .sample(sample), .sample_valid(sample_valid),
    .trigger_out(trigger_out), .arm(arm), .rd_addr(rd_addr),
    .read_finished(read_finished), .rd_data(rd_data),
    .capture_done(capture_done), .start_addr(start_addr));

  la_readout i_readout (
    .clk(clk), .reset(reset), .capture_done(capture_done),
    .start_addr(start_addr), .rd_data(rd_data), .rd_addr(rd_addr),
    .read_finished(read_finished), .out_sample(out_sample), .out_valid(out_valid));

endmodule

// File: design/la_readout.sv
// ******************************
// Logic analyzer readout
// Streams the finished record, oldest first
// ******************************

`timescale 1ns/1ns

module la_readout (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               capture_done,
  input  logic [la_pkg::ADDR_WIDTH-1:0]      start_addr,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     rd_data,
  output logic [la_pkg::ADDR_WIDTH-1:0]      rd_addr,
  output logic                               read_finished,
  output logic [la_pkg::PROBE_WIDTH-1:0]     out_sample,
  output logic                               out_valid
);

  logic                          done_d;
  logic                          done_rise;
  // High while addresses are issued
  logic                          reading;
  logic [la_pkg::ADDR_WIDTH-1:0] read_count;

  // Done edge starts one pass through the record
  assign done_rise = capture_done && !done_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      done_d <= 1'b0;
      reading <= 1'b0;
      read_count <= '0;
      rd_addr <= '0;
    end else begin
      done_d <= capture_done;
      if (done_rise) begin
        reading <= 1'b1;
        read_count <= '0;
        rd_addr <= start_addr;
      end else if (reading) begin
        // Address wraps with the buffer
        rd_addr <= rd_addr + 1'b1;
        read_count <= read_count + 1'b1;
        if (read_count == la_pkg::READ_COUNT_LAST) begin
          reading <= 1'b0;
        end
      end
    end
  end

  // One stage to match the buffer read latency
  // Last strobe and finish pulse line up
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      read_finished <= 1'b0;
    end else begin
      out_valid <= reading;
      read_finished <= reading && (read_count == la_pkg::READ_COUNT_LAST);
    end
  end

  assign out_sample = rd_data;

endmodule

// File: la_capture/la_capture_buffer.sv
// ******************************
// Logic analyzer capture buffer
// Circular record with pre-trigger samples,
// trigger address capture and done flag
// ******************************

`timescale 1ns/1ns

module la_capture_buffer (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     sample,
  input  logic                               sample_valid,
  input  logic                               trigger_out,
  input  logic                               arm,
  input  logic [la_pkg::ADDR_WIDTH-1:0]      rd_addr,
  input  logic                               read_finished,
  output logic [la_pkg::PROBE_WIDTH-1:0]     rd_data,
  output logic                               capture_done,
  output logic [la_pkg::ADDR_WIDTH-1:0]      start_addr
);

  // Record memory
  logic [la_pkg::PROBE_WIDTH-1:0]  mem [la_pkg::BUF_DEPTH];
  // Delay line matching the trigger latency
  logic [la_pkg::PROBE_WIDTH-1:0]  sample_pipe [la_pkg::TRIG_LATENCY];
  logic [la_pkg::TRIG_LATENCY-1:0] valid_pipe;
  logic [la_pkg::PROBE_WIDTH-1:0]  wr_sample;
  logic                            wr_valid;
  logic                            wr_en;
  logic [2:0]                      state;
  logic [la_pkg::ADDR_WIDTH-1:0]   wr_ptr;
  // Pre-sample count, reused for post-samples
  logic [la_pkg::ADDR_WIDTH-1:0]   sample_count;
  logic [la_pkg::ADDR_WIDTH-1:0]   trig_addr;

  // ******************************
  // Trigger alignment
  // Delayed valid pairs with the trigger level for its own sample
  always_ff @(posedge clk) begin
    sample_pipe[0] <= sample;
    for (int i = 1; i < la_pkg::TRIG_LATENCY; i++) begin
      sample_pipe[i] <= sample_pipe[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[la_pkg::TRIG_LATENCY-2:0], sample_valid};
    end
  end

  assign wr_sample = sample_pipe[la_pkg::TRIG_LATENCY-1];
  assign wr_valid = valid_pipe[la_pkg::TRIG_LATENCY-1];

  // Writes in every armed state
  assign wr_en = wr_valid && (state == la_pkg::ST_PRE || state == la_pkg::ST_WAIT ||
                              state == la_pkg::ST_POST);

  // Memory write and registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_sample;
    end
    rd_data <= mem[rd_addr];
  end

  // ******************************
  // Capture FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= la_pkg::ST_IDLE;
      wr_ptr <= '0;
      sample_count <= '0;
    end else begin
      // Write pointer wraps on its own
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      case (state)
        la_pkg::ST_IDLE: begin
          // Arm only counts here, so it is ignored during readout
          if (arm) begin
            sample_count <= '0;
            state <= la_pkg::ST_PRE;
          end
        end
        la_pkg::ST_PRE: begin
          if (wr_valid) begin
            sample_count <= sample_count + 1'b1;
            if (sample_count == la_pkg::PRE_COUNT_LAST) begin
              state <= la_pkg::ST_WAIT;
            end
          end
        end
        la_pkg::ST_WAIT: begin
          // Pre-fill complete, honor the aligned trigger
          if (wr_valid && trigger_out) begin
            sample_count <= '0;
            state <= la_pkg::ST_POST;
          end
        end
        la_pkg::ST_POST: begin
          if (wr_valid) begin
            sample_count <= sample_count + 1'b1;
            if (sample_count == la_pkg::POST_COUNT_LAST) begin
              state <= la_pkg::ST_DONE;
            end
          end
        end
        la_pkg::ST_DONE: begin
          if (read_finished) begin
            state <= la_pkg::ST_IDLE;
          end
        end
        default: state <= la_pkg::ST_IDLE;
      endcase
    end
  end

  // Address of the trigger sample
  always_ff @(posedge clk) begin
    if (state == la_pkg::ST_WAIT && wr_valid && trigger_out) begin
      trig_addr <= wr_ptr;
    end
  end

  // Oldest sample sits PRE_SAMPLES before the trigger, modulo depth
  assign start_addr = trig_addr - la_pkg::PRE_OFFSET;
  assign capture_done = (state == la_pkg::ST_DONE);

endmodule

// File: la_trigger/la_trigger.sv
// ******************************
// Logic analyzer trigger
// Per-line edge and level conditions,
// OR or AND combined into a trigger level
// ******************************

`timescale 1ns/1ns

module la_trigger (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     sample,
  input  logic                               sample_valid,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     edge_detect_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     rise_edge_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     fall_edge_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     low_level_enable,
  input  logic [la_pkg::PROBE_WIDTH-1:0]     high_level_enable,
  input  logic                               trigger_logic,
  output logic                               trigger_out
);

  // Previous valid sample, for edge compare
  logic [la_pkg::PROBE_WIDTH-1:0] prev_sample;
  // Condition flags per line
  logic [la_pkg::PROBE_WIDTH-1:0] edge_flag;
  logic [la_pkg::PROBE_WIDTH-1:0] rise_flag;
  logic [la_pkg::PROBE_WIDTH-1:0] fall_flag;
  logic [la_pkg::PROBE_WIDTH-1:0] low_flag;
  logic [la_pkg::PROBE_WIDTH-1:0] high_flag;
  // One bit per condition class
  logic [4:0] class_hit;
  logic [4:0] class_used;
  logic       trigger_active;

  // ******************************
  // Condition detection
  // Flags update once per valid sample and hold in between
  always_ff @(posedge clk) begin
    if (reset) begin
      prev_sample <= '0;
      edge_flag <= '0;
      rise_flag <= '0;
      fall_flag <= '0;
      low_flag <= '0;
      high_flag <= '0;
    end else if (sample_valid) begin
      prev_sample <= sample;
      edge_flag <= prev_sample ^ sample;
      rise_flag <= ~prev_sample & sample;
      fall_flag <= prev_sample & ~sample;
      low_flag <= ~sample;
      high_flag <= sample;
    end
  end

  // Any enabled line true, per class
  assign class_hit[0] = |(edge_flag & edge_detect_enable);
  assign class_hit[1] = |(rise_flag & rise_edge_enable);
  assign class_hit[2] = |(fall_flag & fall_edge_enable);
  assign class_hit[3] = |(low_flag & low_level_enable);
  assign class_hit[4] = |(high_flag & high_level_enable);

  // Class takes part only with a non-zero mask
  assign class_used[0] = |edge_detect_enable;
  assign class_used[1] = |rise_edge_enable;
  assign class_used[2] = |fall_edge_enable;
  assign class_used[3] = |low_level_enable;
  assign class_used[4] = |high_level_enable;

  // ******************************
  // Combination, 0 is OR and 1 is AND
  // AND with every mask empty never fires
  always_comb begin
    if (trigger_logic) begin
      trigger_active = (|class_used) && (&(class_hit | ~class_used));
    end else begin
      trigger_active = |class_hit;
    end
  end

  // Second register stage of the trigger latency
  always_ff @(posedge clk) begin
    if (reset) begin
      trigger_out <= 1'b0;
    end else begin
      trigger_out <= trigger_active;
    end
  end

endmodule

// File: design/la_sampler.sv
// ******************************
// Logic analyzer sampler
// Divides the clock to the sample rate and
// registers probe and trigger lines
// ******************************

`timescale 1ns/1ns

module la_sampler (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [la_pkg::DATA_WIDTH-1:0]      probe,
  input  logic [la_pkg::TRIG_WIDTH-1:0]      ext_trigger,
  input  logic [la_pkg::DIV_WIDTH-1:0]       sample_div,
  output logic [la_pkg::PROBE_WIDTH-1:0]     sample,
  output logic                               sample_valid
);

  // Clocks left until the next sample
  logic [la_pkg::DIV_WIDTH-1:0] div_count;

  // Divider and valid strobe
  // Count starts at zero so the first sample follows reset release
  always_ff @(posedge clk) begin
    if (reset) begin
      div_count <= '0;
      sample_valid <= 1'b0;
    end else if (div_count == '0) begin
      div_count <= sample_div;
      sample_valid <= 1'b1;
    end else begin
      div_count <= div_count - 1'b1;
      sample_valid <= 1'b0;
    end
  end

  // Sample word, only loaded on the reload cycle
  // Trigger lines go above the probe lines
  always_ff @(posedge clk) begin
    if (div_count == '0) begin
      sample <= {ext_trigger, probe};
    end
  end

endmodule

// File: common/la_pkg.sv
// ******************************
// Logic analyzer shared constants
// Line widths, record depth and capture split
// ******************************

package la_pkg;

  // Probe lines and external trigger lines
  localparam int DATA_WIDTH = 16;
  localparam int TRIG_WIDTH = 2;
  // Trigger lines sit above the data lines in a sample word
  localparam int PROBE_WIDTH = DATA_WIDTH + TRIG_WIDTH;

  // Sample period is the divider setting plus one
  localparam int DIV_WIDTH = 8;

  // ******************************
  // Capture record layout
  localparam int BUF_DEPTH = 64;
  localparam int ADDR_WIDTH = 6;
  localparam int PRE_SAMPLES = 16;
  // Trigger sample itself takes the remaining slot
  localparam int POST_SAMPLES = BUF_DEPTH - PRE_SAMPLES - 1;

  // Valid sample to trigger level, in clocks
  localparam int TRIG_LATENCY = 2;

  // Address-wide forms of the counts above
  localparam logic [ADDR_WIDTH-1:0] PRE_OFFSET = ADDR_WIDTH'(PRE_SAMPLES);
  localparam logic [ADDR_WIDTH-1:0] PRE_COUNT_LAST = ADDR_WIDTH'(PRE_SAMPLES - 1);
  localparam logic [ADDR_WIDTH-1:0] POST_COUNT_LAST = ADDR_WIDTH'(POST_SAMPLES - 1);
  localparam logic [ADDR_WIDTH-1:0] READ_COUNT_LAST = ADDR_WIDTH'(BUF_DEPTH - 1);

  // Capture FSM state codes
  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_PRE = 3'd1;
  localparam logic [2:0] ST_WAIT = 3'd2;
  localparam logic [2:0] ST_POST = 3'd3;
  localparam logic [2:0] ST_DONE = 3'd4;

endpackage
